/* common/fx_pkg.sv */
// --------------------------------------------------
// number format shared by the whole probit datapath
// every word is signed Q16.16 unless noted otherwise
// --------------------------------------------------

package fx_pkg;

    // --------------------------------------------------
    // word layout
    // --------------------------------------------------
    localparam int WIDTH = 32;              // full word
    localparam int QINT  = 16;              // integer bits incl. sign
    localparam int QFRAC = WIDTH - QINT;    // fraction bits

    typedef logic signed [WIDTH-1:0] fx_t;

    // handy constants
    localparam fx_t ONE  = 32'sh0001_0000;  // 1.0
    localparam fx_t HALF = 32'sh0000_8000;  // 0.5

endpackage

/* common/zs_pkg.sv */
// --------------------------------------------------
// constants for the probit approximation
// only valid for Q16.16, all values truncated
// --------------------------------------------------

package zs_pkg;

    // zelen-severo numerator
    localparam fx_pkg::fx_t C0 = 32'sd164856;   // 2.515517
    localparam fx_pkg::fx_t C1 = 32'sd52615;    // 0.802853
    localparam fx_pkg::fx_t C2 = 32'sd676;      // 0.010328

    // zelen-severo denominator, constant term is 1.0
    localparam fx_pkg::fx_t D1 = 32'sd93899;    // 1.432788
    localparam fx_pkg::fx_t D2 = 32'sd12403;    // 0.189269
    localparam fx_pkg::fx_t D3 = 32'sd85;       // 0.001308

    // magnitude 2*ln2, turns -log2 q into -2*ln q
    localparam fx_pkg::fx_t NEG_TWO_LN2 = 32'sd90852;

    // --------------------------------------------------
    // log2(1 + i/32), indexed by the 5 bits below the leading one
    // --------------------------------------------------
    localparam fx_pkg::fx_t LOG2_FRAC [32] = '{
        32'sd0,     32'sd2909,  32'sd5731,  32'sd8472,
        32'sd11136, 32'sd13726, 32'sd16248, 32'sd18704,
        32'sd21097, 32'sd23432, 32'sd25710, 32'sd27935,
        32'sd30109, 32'sd32234, 32'sd34312, 32'sd36345,
        32'sd38336, 32'sd40285, 32'sd42195, 32'sd44068,
        32'sd45904, 32'sd47704, 32'sd49472, 32'sd51207,
        32'sd52910, 32'sd54584, 32'sd56228, 32'sd57844,
        32'sd59433, 32'sd60996, 32'sd62534, 32'sd64047
    };

    // pipeline depths in clock cycles
    localparam int TAIL_LATENCY = 4;    // p in to t out
    localparam int ZS_LATENCY   = 6;    // t in to z out

endpackage

/* hdl/fx_mul.sv */
// --------------------------------------------------
// signed Q16.16 multiply, one register stage
// product is truncated, overflow wraps silently
// --------------------------------------------------
`timescale 1ns/100ps

module fx_mul (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        valid_in,
    input  fx_pkg::fx_t a,
    input  fx_pkg::fx_t b,
    output logic        valid_out,
    output fx_pkg::fx_t result
);

    logic signed [2*fx_pkg::WIDTH-1:0] product;    // full Q32.32

    assign product = a * b;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_out <= 1'b0;
        end else begin
            valid_out <= valid_in;
        end
    end

    // drop the low fraction bits
    always_ff @(posedge clk) begin
        if (valid_in) begin
            result <= product[fx_pkg::QFRAC +: fx_pkg::WIDTH];
        end
    end

endmodule

/* hdl/fx_div.sv */
// --------------------------------------------------
// Q16.16 divide, one register stage
// operands taken as non-negative, denominator nonzero
// --------------------------------------------------
`timescale 1ns/100ps

module fx_div (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        valid_in,
    input  fx_pkg::fx_t numerator,
    input  fx_pkg::fx_t denominator,
    output logic        valid_out,
    output fx_pkg::fx_t result
);

    logic [fx_pkg::WIDTH+fx_pkg::QFRAC-1:0] dividend;
    logic [fx_pkg::WIDTH+fx_pkg::QFRAC-1:0] quotient;
    logic [fx_pkg::WIDTH:0]                 remainder;  // one spare bit for the compare

    // restoring long division, one quotient bit per step
    always_comb begin
        dividend  = {numerator, {fx_pkg::QFRAC{1'b0}}};
        remainder = '0;
        quotient  = '0;
        for (int i = fx_pkg::WIDTH + fx_pkg::QFRAC - 1; i >= 0; i--) begin
            remainder = {remainder[fx_pkg::WIDTH-1:0], dividend[i]};
            if (remainder >= {1'b0, denominator}) begin
                remainder   = remainder - {1'b0, denominator};
                quotient[i] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_out <= 1'b0;
        end else begin
            valid_out <= valid_in;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_in) begin
            result <= quotient[fx_pkg::WIDTH-1:0];  // upper bits are overflow
        end
    end

endmodule

/* hdl/fx_sqrt.sv */
// --------------------------------------------------
// Q16.16 square root, one register stage
// input must be non-negative, result truncated
// --------------------------------------------------
`timescale 1ns/100ps

module fx_sqrt (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        valid_in,
    input  fx_pkg::fx_t x,
    output logic        valid_out,
    output fx_pkg::fx_t root
);

    logic [fx_pkg::WIDTH+fx_pkg::QFRAC-1:0] radicand;  // x scaled by 2^16
    logic [fx_pkg::WIDTH-1:0]               rem;
    logic [fx_pkg::WIDTH-1:0]               trial;
    logic [fx_pkg::WIDTH-1:0]               res;

    // digit recurrence, two radicand bits per result bit
    always_comb begin
        radicand = {x, {fx_pkg::QFRAC{1'b0}}};
        rem      = '0;
        res      = '0;
        trial    = '0;
        for (int i = (fx_pkg::WIDTH + fx_pkg::QFRAC) / 2 - 1; i >= 0; i--) begin
            rem   = {rem[fx_pkg::WIDTH-3:0], radicand[2*i +: 2]};
            trial = {res[fx_pkg::WIDTH-3:0], 2'b01};
            if (rem >= trial) begin
                rem = rem - trial;
                res = {res[fx_pkg::WIDTH-2:0], 1'b1};
            end else begin
                res = {res[fx_pkg::WIDTH-2:0], 1'b0};
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_out <= 1'b0;
        end else begin
            valid_out <= valid_in;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_in) begin
            root <= res;    // at most 24 significant bits
        end
    end

endmodule

/* tail_transform/fx_tail_transform.sv */
// --------------------------------------------------
// p -> t = sqrt(-2 ln q), 4 cycles, one sample per cycle
// p must lie strictly inside (0, 1), nothing is checked
// --------------------------------------------------
`timescale 1ns/100ps

module fx_tail_transform (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        p_valid,
    input  fx_pkg::fx_t p,
    output logic        t_valid,
    output fx_pkg::fx_t t,
    output logic        negate
);

    logic                     v1, v2, v3;
    logic                     neg1, neg2, neg3;    // flag delay line
    logic [fx_pkg::QFRAC-1:0] q;                   // folded tail, at most 0.5
    logic [3:0]               lead;                // leading one position
    logic [fx_pkg::QFRAC-1:0] norm;
    logic [4:0]               frac_idx;
    fx_pkg::fx_t              int_part;
    fx_pkg::fx_t              nlog_next;
    fx_pkg::fx_t              nlog;                // -log2 q
    fx_pkg::fx_t              scaled;              // -2 ln q

    // --------------------------------------------------
    // stage 1, fold the upper tail onto the lower one
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (p_valid) begin
            q <= (p <= fx_pkg::HALF) ? p[fx_pkg::QFRAC-1:0]
                                     : fx_pkg::QFRAC'(fx_pkg::ONE - p);
        end
    end

    // --------------------------------------------------
    // stage 2, -log2 q from leading one and table
    // --------------------------------------------------
    always_comb begin
        lead = '0;
        for (int i = 0; i < fx_pkg::QFRAC; i++) begin
            if (q[i]) lead = 4'(i);     // highest set bit wins
        end
        norm      = q << (4'd15 - lead);   // leading one to bit 15
        frac_idx  = norm[14:10];
        // integer part of -log2 q is 16 - lead
        int_part  = {11'd0, 5'd16 - {1'b0, lead}, 16'd0};
        nlog_next = int_part - zs_pkg::LOG2_FRAC[frac_idx];
    end

    always_ff @(posedge clk) begin
        if (v1) begin
            nlog <= nlog_next;
        end
    end

    // valids and the negate flag
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            v1     <= 1'b0;
            v2     <= 1'b0;
            neg1   <= 1'b0;
            neg2   <= 1'b0;
            neg3   <= 1'b0;
            negate <= 1'b0;
        end else begin
            v1 <= p_valid;
            v2 <= v1;
            if (p_valid) neg1   <= (p < fx_pkg::HALF);
            if (v1)      neg2   <= neg1;
            if (v2)      neg3   <= neg2;
            if (v3)      negate <= neg3;    // lands with t
        end
    end

    // stage 3, scale by 2 ln 2
    fx_mul mul_ln (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_in  (v2),
        .a         (nlog),
        .b         (zs_pkg::NEG_TWO_LN2),
        .valid_out (v3),
        .result    (scaled)
    );

    // stage 4
    fx_sqrt sqrt_t (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_in  (v3),
        .x         (scaled),
        .valid_out (t_valid),
        .root      (t)
    );

endmodule

/* zelen_severo/fx_inv_cdf_zs.sv */
// --------------------------------------------------
// z = t - num(t)/den(t), sign from negate, 6 cycles
// expects t >= 0 so the denominator stays above 1.0
// --------------------------------------------------
`timescale 1ns/100ps

module fx_inv_cdf_zs (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        t_valid,
    input  fx_pkg::fx_t t,
    input  logic        negate,
    output logic        z_valid,
    output fx_pkg::fx_t z
);

    logic        v1, v2, v3, v4, v5;
    logic [4:0]  stage_v;
    logic [4:0]  neg_pipe;
    fx_pkg::fx_t t_pipe [5];                // copy of t for the final subtract
    fx_pkg::fx_t t2, t3;
    fx_pkg::fx_t c1t, c2t2, d1t, d2t2, d3t3;
    fx_pkg::fx_t c1t_q, d1t_q;
    fx_pkg::fx_t num, num_q;
    fx_pkg::fx_t den_part, den;
    fx_pkg::fx_t ratio;
    fx_pkg::fx_t diff;

    assign stage_v = {v4, v3, v2, v1, t_valid};

    // --------------------------------------------------
    // products, cycles 1 to 3
    // --------------------------------------------------
    fx_mul mul_t2 (
        .clk(clk), .rst_n(rst_n), .valid_in(t_valid),
        .a(t), .b(t), .valid_out(v1), .result(t2)
    );
    fx_mul mul_c1t (
        .clk(clk), .rst_n(rst_n), .valid_in(t_valid),
        .a(zs_pkg::C1), .b(t), .valid_out(), .result(c1t)
    );
    fx_mul mul_d1t (
        .clk(clk), .rst_n(rst_n), .valid_in(t_valid),
        .a(zs_pkg::D1), .b(t), .valid_out(), .result(d1t)
    );
    fx_mul mul_t3 (
        .clk(clk), .rst_n(rst_n), .valid_in(v1),
        .a(t2), .b(t_pipe[0]), .valid_out(v2), .result(t3)
    );
    fx_mul mul_c2t2 (
        .clk(clk), .rst_n(rst_n), .valid_in(v1),
        .a(zs_pkg::C2), .b(t2), .valid_out(), .result(c2t2)
    );
    fx_mul mul_d2t2 (
        .clk(clk), .rst_n(rst_n), .valid_in(v1),
        .a(zs_pkg::D2), .b(t2), .valid_out(), .result(d2t2)
    );
    fx_mul mul_d3t3 (
        .clk(clk), .rst_n(rst_n), .valid_in(v2),
        .a(zs_pkg::D3), .b(t3), .valid_out(v3), .result(d3t3)
    );

    // --------------------------------------------------
    // sums and the t copy
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (stage_v[0]) t_pipe[0] <= t;
        for (int i = 1; i < 5; i++) begin
            if (stage_v[i]) t_pipe[i] <= t_pipe[i-1];
        end
        if (v1) begin                       // hold linear terms one cycle
            c1t_q <= c1t;
            d1t_q <= d1t;
        end
        if (v2) begin
            num      <= zs_pkg::C0 + c1t_q + c2t2;
            den_part <= fx_pkg::ONE + d1t_q + d2t2;
        end
        if (v3) begin
            num_q <= num;                   // wait for den
            den   <= den_part + d3t3;
        end
    end

    // cycle 5
    fx_div div_ratio (
        .clk         (clk),
        .rst_n       (rst_n),
        .valid_in    (v4),
        .numerator   (num_q),
        .denominator (den),
        .valid_out   (v5),
        .result      (ratio)
    );

    assign diff = t_pipe[4] - ratio;

    // cycle 6, sign and output
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            v4       <= 1'b0;
            z_valid  <= 1'b0;
            neg_pipe <= '0;
            z        <= '0;
        end else begin
            v4      <= v3;
            z_valid <= v5;
            if (stage_v[0]) neg_pipe[0] <= negate;
            for (int i = 1; i < 5; i++) begin
                if (stage_v[i]) neg_pipe[i] <= neg_pipe[i-1];
            end
            if (v5) begin
                z <= neg_pipe[4] ? -diff : diff;
            end
        end
    end

endmodule

/* hdl/fx_inv_cdf.sv */
// --------------------------------------------------
// probit top, p in (0,1) Q16.16 -> z Q16.16
// 10 cycle latency, no back-pressure on the output
// --------------------------------------------------
`timescale 1ns/100ps

module fx_inv_cdf (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        p_valid,
    input  fx_pkg::fx_t p,
    output logic        z_valid,
    output fx_pkg::fx_t z
);

    logic        t_valid;
    fx_pkg::fx_t t;
    logic        negate;    // p was below one half

    fx_tail_transform tail_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .p_valid (p_valid),
        .p       (p),
        .t_valid (t_valid),
        .t       (t),
        .negate  (negate)
    );

    fx_inv_cdf_zs zs_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .t_valid (t_valid),
        .t       (t),
        .negate  (negate),
        .z_valid (z_valid),
        .z       (z)
    );

endmodule

/* verif/tb_fx_inv_cdf.sv */
// --------------------------------------------------
// trace-driven testbench for the probit pipeline
// run from the project root so the trace path resolves
// --------------------------------------------------
`timescale 1ns/100ps

module tb_fx_inv_cdf;

    localparam int MAX_SAMPLES  = 64;
    localparam int RESET_CYCLES = 10;
    localparam int LATENCY      = zs_pkg::TAIL_LATENCY + zs_pkg::ZS_LATENCY;

    logic        clk;
    logic        rst_n;
    logic        p_valid;
    fx_pkg::fx_t p;
    logic        z_valid;
    fx_pkg::fx_t z;

    logic [31:0] trace_mem [0:3*MAX_SAMPLES-1];    // gap, p, expected z
    int          num_samples;
    int          checked;
    int          cycle;
    int          watchdog_cycles;
    logic        trace_ready;

    // one entry per sample in flight
    logic [31:0] exp_q [$];
    fx_pkg::fx_t p_q [$];
    int          stamp_q [$];
    int          idx_q [$];
    fx_pkg::fx_t result_by_p [fx_pkg::fx_t];      // for the p / 1-p pairs

    fx_inv_cdf fx_inv_cdf_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .p_valid (p_valid),
        .p       (p),
        .z_valid (z_valid),
        .z       (z)
    );

    always #2 clk = ~clk;   // 4 ns period

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TB FAILED");
        $fatal(1, "stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("FAIL %s expected %h actual %h", name, expected, actual));
        end
    endtask

    // --------------------------------------------------
    // stimulus from the trace
    // --------------------------------------------------
    initial begin : stimulus
        int total_gaps;
        clk         = 1'b0;
        rst_n       = 1'b0;
        p_valid     = 1'b0;
        p           = '0;
        cycle       = 0;
        checked     = 0;
        trace_ready = 1'b0;
        total_gaps  = 0;
        // words past the end of the trace keep this marker
        for (int addr = 0; addr < 3*MAX_SAMPLES; addr++) begin
            trace_mem[addr] = ~addr;
        end
        $readmemh("verif/fx_inv_cdf_trace.txt", trace_mem);
        num_samples = 0;
        while (num_samples < MAX_SAMPLES &&
               trace_mem[3*num_samples] !== ~(3*num_samples)) begin
            num_samples++;
        end
        if (num_samples == 0) begin
            abort_run("no samples could be read from the trace file");
        end
        for (int i = 0; i < num_samples; i++) begin
            total_gaps += trace_mem[3*i];
        end
        watchdog_cycles = RESET_CYCLES + num_samples + total_gaps + LATENCY + 20;
        trace_ready     = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;

        for (int i = 0; i < num_samples; i++) begin
            repeat (trace_mem[3*i]) begin  // idle cycles
                @(posedge clk);
                #1;
            end
            p_valid = 1'b1;
            p       = trace_mem[3*i+1];
            exp_q.push_back(trace_mem[3*i+2]);
            p_q.push_back(trace_mem[3*i+1]);
            stamp_q.push_back(cycle);       // DUT takes it on the next edge
            idx_q.push_back(i);
            @(posedge clk);
            #1;
            p_valid = 1'b0;
        end

        wait (checked == num_samples);
        repeat (LATENCY) @(posedge clk);    // room for a stray beat to show up
        if (checked == num_samples && exp_q.size() == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            abort_run("run ended with results missing or left over");
        end
    end

    // --------------------------------------------------
    // output monitor
    // --------------------------------------------------
    always @(posedge clk) begin : monitor
        logic [31:0] exp_z;
        fx_pkg::fx_t p_in;
        fx_pkg::fx_t sum;
        int          stamp;
        string       name;
        if (rst_n) begin
            if (z_valid) begin
                if (exp_q.size() == 0) begin
                    abort_run("z_valid came high with no sample in flight");
                end else begin
                    exp_z = exp_q.pop_front();
                    p_in  = p_q.pop_front();
                    stamp = stamp_q.pop_front();
                    name  = $sformatf("sample %0d p=%h", idx_q.pop_front(), p_in);
                    if (cycle != stamp + LATENCY) begin
                        abort_run($sformatf("%s came out at cycle %0d instead of cycle %0d",
                                            name, cycle, stamp + LATENCY));
                    end
                    check_value(name, exp_z, z);
                    // half has no partner and no sign
                    if (p_in != fx_pkg::HALF) begin
                        check_value({name, " sign"}, {31'd0, p_in < fx_pkg::HALF},
                                    {31'd0, z[31]});
                        if (result_by_p.exists(fx_pkg::ONE - p_in)) begin
                            sum = z + result_by_p[fx_pkg::ONE - p_in];
                            check_value({name, " symmetry"}, 32'd1,
                                        {31'd0, sum >= -1 && sum <= 1});
                        end
                        result_by_p[p_in] = z;
                    end
                    checked++;
                end
            end else if (checked == 0) begin
                check_value("idle z after reset", 32'd0, z);   // reset value holds
            end
        end
    end

    // --------------------------------------------------
    // watchdog
    // --------------------------------------------------
    initial begin : watchdog
        wait (trace_ready);
        repeat (watchdog_cycles) @(posedge clk);
        abort_run($sformatf("timeout after %0d cycles with %0d of %0d samples checked",
                            watchdog_cycles, checked, num_samples));
    end

endmodule

/* verif/fx_inv_cdf_trace.txt */
// columns: gap (idle cycles before the sample), p (Q16.16), expected z (Q16.16)
// expected z is bit-accurate with truncation; the comment holds the true probit
// first sample, output due after the idle stretch
05 00008000 ffffffff // p 0.5, true z 0.0
// back-to-back burst, pairs p and 1-p
00 00004000 ffff5369 // p 0.25, true z -0.6745
00 0000c000 0000ac97 // p 0.75, true z 0.6745
00 00000002 fffbfdc2 // p 2^-15, true z -4.0087
00 0000fffe 0004023e // p 1-2^-15, true z 4.0087
00 00001800 fffeae8b // p 0.09375, true z -1.3180
00 0000e800 00015175 // p 0.90625, true z 1.3180
00 00000600 fffe031d // p 0.0234375, true z -1.9874
00 0000fa00 0001fce3 // p 0.9765625, true z 1.9874
00 00008000 ffffffff // p 0.5, true z 0.0
// gapped samples
03 0000c000 0000ac97 // p 0.75, true z 0.6745
07 00000600 fffe031d // p 0.0234375, true z -1.9874
01 0000fffe 0004023e // p 1-2^-15, true z 4.0087
0c 00001800 fffeae8b // p 0.09375, true z -1.3180
02 00004000 ffff5369 // p 0.25, true z -0.6745
00 0000e800 00015175 // p 0.90625, true z 1.3180

/* fx_inv_cdf.f */
common/fx_pkg.sv
common/zs_pkg.sv
hdl/fx_mul.sv
hdl/fx_div.sv
hdl/fx_sqrt.sv
tail_transform/fx_tail_transform.sv
zelen_severo/fx_inv_cdf_zs.sv
hdl/fx_inv_cdf.sv
verif/tb_fx_inv_cdf.sv

/* Bender.yml */
package:
  name: fx_inv_cdf

sources:
  - common/fx_pkg.sv
  - common/zs_pkg.sv
  - hdl/fx_mul.sv
  - hdl/fx_div.sv
  - hdl/fx_sqrt.sv
  - tail_transform/fx_tail_transform.sv
  - zelen_severo/fx_inv_cdf_zs.sv
  - hdl/fx_inv_cdf.sv
  - target: test
    files:
      - verif/tb_fx_inv_cdf.sv
